//--- flist.f
+incdir+rtl
rtl/smc_pkg.sv
rtl/smc_access_decode.sv
rtl/smc_access_sequencer.sv
rtl/smc_addr_gen.sv
rtl/smc_lite_top.sv
verification/smc_lite_sva.sv
verification/smc_lite_tb.sv

//--- rtl/smc_access_decode.sv
`timescale 1ns/1ps
`include "smc_params.svh"
`default_nettype none

module smc_access_decode
(
   input  wire                        sys_clk4,
   input  wire                        n_sys_reset4,
   input  wire                        req_valid,      // Request strobe
   input  wire smc_pkg::smc_size_t    req_xfer_size,  // Requested transfer size
   input  wire smc_pkg::smc_size_t    bus_size,       // Static bus width
   output logic                       valid_access,   // Legal request this cycle
   output smc_pkg::smc_size_t         v_xfer_size,
   output smc_pkg::smc_size_t         v_bus_size,
   output smc_pkg::smc_acc_cnt_t      num_access,     // Accesses needed minus one
   output logic                       req_error       // Illegal size seen last cycle
);

   logic                  legal_size;
   smc_pkg::smc_size_t    r_xfer_size;    // Sizes of the running transfer
   smc_pkg::smc_size_t    r_bus_size;

   // Size code 3 has no transfer behind it
   assign legal_size   = (req_xfer_size != 2'b11);
   assign valid_access = req_valid && legal_size;

   // ------------------------------
   // Size store
   // ------------------------------
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
      begin
         r_xfer_size <= `SMC_XSIZ_8;
         r_bus_size  <= `SMC_BSIZ_8;
      end
      else if (valid_access)
      begin
         r_xfer_size <= req_xfer_size;     // Held for the whole transfer
         r_bus_size  <= bus_size;
      end
   end

   // Current request wins in its own cycle
   assign v_xfer_size = valid_access ? req_xfer_size : r_xfer_size;
   assign v_bus_size  = valid_access ? bus_size      : r_bus_size;

   // ------------------------------
   // Access count
   // ------------------------------
   always_comb
   begin
      num_access = 2'd0;                                 // Fits in one access
      if ((v_xfer_size == `SMC_XSIZ_32) && (v_bus_size == `SMC_BSIZ_8))
         num_access = 2'd3;                              // Four byte accesses
      else if (((v_xfer_size == `SMC_XSIZ_32) && (v_bus_size == `SMC_BSIZ_16)) ||
               ((v_xfer_size == `SMC_XSIZ_16) && (v_bus_size == `SMC_BSIZ_8)))
         num_access = 2'd1;                              // Two accesses
   end

   // Error strobe, one cycle late
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         req_error <= 1'b0;
      else
         req_error <= req_valid && !legal_size;
   end

endmodule

`default_nettype wire

//--- rtl/smc_access_sequencer.sv
`timescale 1ns/1ps
`include "smc_params.svh"
`default_nettype none

module smc_access_sequencer
(
   input  wire                        sys_clk4,
   input  wire                        n_sys_reset4,
   input  wire                        valid_access,   // Start of a new transfer
   input  wire smc_pkg::smc_acc_cnt_t num_access,     // Accesses minus one
   input  wire smc_pkg::smc_wait_t    wait_states,    // Extra cycles per access
   output smc_pkg::smc_state_t        smc_nextstate,
   output logic                       smc_done,       // Last cycle of an access
   output smc_pkg::smc_acc_cnt_t      r_num_access,   // Accesses still to come
   output logic                       busy,
   output logic                       xfer_done       // One cycle after last access
);

   smc_pkg::smc_state_t   smc_state;
   smc_pkg::smc_wait_t    wait_cnt;       // Cycles spent in this access
   logic                  last_done;      // Final access ends now

   assign busy      = (smc_state == smc_pkg::SMC_RW);
   assign smc_done  = busy && (wait_cnt == wait_states);
   assign last_done = smc_done && (r_num_access == 2'd0);

   // ------------------------------
   // Next state
   // ------------------------------
   always_comb
   begin
      smc_nextstate = smc_state;
      case (smc_state)
         smc_pkg::SMC_IDLE:
         begin
            if (valid_access)
               smc_nextstate = smc_pkg::SMC_RW;   // No gap before first access
         end
         smc_pkg::SMC_RW:
         begin
            if (last_done)
               smc_nextstate = smc_pkg::SMC_IDLE;
         end
         default:
            smc_nextstate = smc_pkg::SMC_IDLE;
      endcase
   end

   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         smc_state <= smc_pkg::SMC_IDLE;
      else
         smc_state <= smc_nextstate;
   end

   // ------------------------------
   // Wait and access counters
   // ------------------------------
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         wait_cnt <= '0;
      else if (!busy || smc_done)
         wait_cnt <= '0;                         // Next access starts from zero
      else
         wait_cnt <= wait_cnt + smc_pkg::smc_wait_t'(1);
   end

   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         r_num_access <= 2'd0;
      else if (!busy && valid_access)
         r_num_access <= num_access;             // Strobes while busy are dropped
      else if (smc_done && (r_num_access != 2'd0))
         r_num_access <= r_num_access - smc_pkg::smc_acc_cnt_t'(1);
   end

   // Completion pulse
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         xfer_done <= 1'b0;
      else
         xfer_done <= last_done;
   end

endmodule

`default_nettype wire

//--- rtl/smc_addr_gen.sv
`timescale 1ns/1ps
`include "smc_params.svh"
`default_nettype none

module smc_addr_gen
(
   input  wire                        sys_clk4,
   input  wire                        n_sys_reset4,
   input  wire                        valid_access,   // First access of a transfer
   input  wire smc_pkg::smc_addr_t    req_addr,       // Only valid with the strobe
   input  wire                        req_cs,         // Internal chip select
   input  wire smc_pkg::smc_size_t    v_xfer_size,
   input  wire smc_pkg::smc_size_t    v_bus_size,
   input  wire smc_pkg::smc_acc_cnt_t r_num_access,   // Accesses still to come
   input  wire                        smc_done,       // Current access ends
   input  wire smc_pkg::smc_state_t   smc_nextstate,
   output smc_pkg::smc_addr_t         smc_addr,       // External address
   output logic                       smc_n_cs,       // External chip select
   output smc_pkg::smc_n_be_t         smc_n_be        // External byte enables
);

   logic                  r_cs;           // Chip select of running transfer
   logic [1:0]            r_addr;         // Low request address bits
   logic                  v_cs;
   logic [1:0]            v_addr;
   logic [1:0]            first_lo;       // Low bits of first access
   logic [1:0]            next_lo;        // Low bits of following access
   logic                  next_access;    // A non-final access ends
   smc_pkg::smc_n_be_t    n_be;           // Unregistered lane enables

   // ------------------------------
   // Request store
   // ------------------------------
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
      begin
         r_cs   <= 1'b0;
         r_addr <= 2'b00;
      end
      else if (valid_access)
      begin
         r_cs   <= req_cs;
         r_addr <= req_addr[1:0];
      end
   end

   // Request values in the strobe cycle, stored ones later
   assign v_cs   = valid_access ? req_cs        : r_cs;
   assign v_addr = valid_access ? req_addr[1:0] : r_addr;

   // ------------------------------
   // Low address bits
   // ------------------------------
   // Little endian order, highest lane goes out first
   always_comb
   begin
      case (v_xfer_size)
         `SMC_XSIZ_32:
         begin
            if (v_bus_size == `SMC_BSIZ_8)
               first_lo = 2'b11;                    // Byte 3 first
            else if (v_bus_size == `SMC_BSIZ_16)
               first_lo = 2'b10;                    // Upper halfword first
            else
               first_lo = 2'b00;                    // Whole word at once
         end
         `SMC_XSIZ_16:
         begin
            if (v_bus_size == `SMC_BSIZ_8)
               first_lo = {req_addr[1], 1'b1};      // Odd byte of the halfword
            else
               first_lo = {req_addr[1], 1'b0};
         end
         default:
            first_lo = req_addr[1:0];               // Byte goes out as addressed
      endcase
   end

   always_comb
   begin
      case ({v_xfer_size, v_bus_size})
         {`SMC_XSIZ_32, `SMC_BSIZ_8}:
            next_lo = r_num_access - 2'd1;          // Count left equals next lane
         {`SMC_XSIZ_32, `SMC_BSIZ_16}:
            next_lo = 2'b00;                        // Lower halfword
         {`SMC_XSIZ_16, `SMC_BSIZ_8}:
            next_lo = {r_addr[1], 1'b0};            // Even byte
         default:
            next_lo = r_addr;                       // Single access pairs
      endcase
   end

   // Last access keeps its address
   assign next_access = smc_done && (r_num_access != 2'd0);

   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         smc_addr <= '0;
      else if (valid_access)
         smc_addr <= {req_addr[31:2], first_lo};    // Upper bits fixed for transfer
      else if (next_access)
         smc_addr[1:0] <= next_lo;
   end

   // ------------------------------
   // Internal byte enables
   // ------------------------------
   always_comb
   begin
      n_be = 4'b1111;                               // Nothing selected
      if (v_cs)
      begin
         case (v_bus_size)
            `SMC_BSIZ_8:
               n_be = 4'b1110;                      // Always lane 0
            `SMC_BSIZ_16:
            begin
               if (v_xfer_size == `SMC_XSIZ_8)
                  n_be = v_addr[0] ? 4'b1101 : 4'b1110;
               else
                  n_be = 4'b1100;                   // Both halfword lanes
            end
            default:
            begin
               // 32 bit bus, code 3 lands here too
               case (v_xfer_size)
                  `SMC_XSIZ_8:
                     n_be = ~(4'b0001 << v_addr);   // One lane by address
                  `SMC_XSIZ_16:
                     n_be = v_addr[1] ? 4'b0011 : 4'b1100;
                  default:
                     n_be = 4'b0000;                // Full word
               endcase
            end
         endcase
      end
   end

   // ------------------------------
   // External strobes
   // ------------------------------
   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         smc_n_cs <= 1'b1;
      else if (smc_nextstate == smc_pkg::SMC_RW)
         smc_n_cs <= ~v_cs;                         // Low only for a selected request
      else
         smc_n_cs <= 1'b1;
   end

   always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
   begin
      if (!n_sys_reset4)
         smc_n_be <= 4'hF;
      else if (smc_nextstate == smc_pkg::SMC_RW)
         smc_n_be <= n_be;
      else
         smc_n_be <= 4'hF;                          // Released with the chip select
   end

endmodule

`default_nettype wire

//--- rtl/smc_lite_top.sv
`timescale 1ns/1ps
`include "smc_params.svh"
`default_nettype none

module smc_lite_top
(
   input  wire                        sys_clk4,
   input  wire                        n_sys_reset4,
   input  wire                        req_valid,      // One cycle request strobe
   input  wire smc_pkg::smc_addr_t    req_addr,
   input  wire smc_pkg::smc_size_t    req_xfer_size,
   input  wire                        req_cs,
   input  wire smc_pkg::smc_size_t    bus_size,       // Static configuration
   input  wire smc_pkg::smc_wait_t    wait_states,
   output wire                        busy,
   output wire                        xfer_done,
   output wire                        req_error,
   output wire smc_pkg::smc_addr_t    smc_addr,
   output wire                        smc_n_cs,
   output wire smc_pkg::smc_n_be_t    smc_n_be
);

   // ------------------------------
   // Stage wiring
   // ------------------------------
   wire                        valid_access;
   wire smc_pkg::smc_size_t    v_xfer_size;
   wire smc_pkg::smc_size_t    v_bus_size;
   wire smc_pkg::smc_acc_cnt_t num_access;
   wire smc_pkg::smc_acc_cnt_t r_num_access;
   wire smc_pkg::smc_state_t   smc_nextstate;
   wire                        smc_done;

   // Decode
   smc_access_decode decode_i
   (
      .sys_clk4      (sys_clk4),
      .n_sys_reset4  (n_sys_reset4),
      .req_valid     (req_valid),
      .req_xfer_size (req_xfer_size),
      .bus_size      (bus_size),
      .valid_access  (valid_access),
      .v_xfer_size   (v_xfer_size),
      .v_bus_size    (v_bus_size),
      .num_access    (num_access),
      .req_error     (req_error)
   );

   // Execute
   smc_access_sequencer sequencer_i
   (
      .sys_clk4      (sys_clk4),
      .n_sys_reset4  (n_sys_reset4),
      .valid_access  (valid_access),
      .num_access    (num_access),
      .wait_states   (wait_states),
      .smc_nextstate (smc_nextstate),
      .smc_done      (smc_done),
      .r_num_access  (r_num_access),
      .busy          (busy),
      .xfer_done     (xfer_done)
   );

   // Result
   smc_addr_gen addr_gen_i
   (
      .sys_clk4      (sys_clk4),
      .n_sys_reset4  (n_sys_reset4),
      .valid_access  (valid_access),
      .req_addr      (req_addr),
      .req_cs        (req_cs),
      .v_xfer_size   (v_xfer_size),
      .v_bus_size    (v_bus_size),
      .r_num_access  (r_num_access),
      .smc_done      (smc_done),
      .smc_nextstate (smc_nextstate),
      .smc_addr      (smc_addr),
      .smc_n_cs      (smc_n_cs),
      .smc_n_be      (smc_n_be)
   );

endmodule

`default_nettype wire

//--- rtl/smc_params.svh
`ifndef SMC_PARAMS_SVH
`define SMC_PARAMS_SVH

`default_nettype none

// ------------------------------
// Transfer size codes
// ------------------------------
`define SMC_XSIZ_8    2'd0          // Byte transfer
`define SMC_XSIZ_16   2'd1          // Halfword transfer
`define SMC_XSIZ_32   2'd2          // Word transfer

// ------------------------------
// External bus width codes
// ------------------------------
`define SMC_BSIZ_8    2'd0          // 8 bit memory
`define SMC_BSIZ_16   2'd1          // 16 bit memory
`define SMC_BSIZ_32   2'd2          // 32 bit memory, code 3 decodes the same

// Width of the wait-state setting
`define SMC_WAIT_W    2

`default_nettype wire

`endif

//--- rtl/smc_pkg.sv
`include "smc_params.svh"
`default_nettype none

package smc_pkg;

   // ------------------------------
   // Vector types
   // ------------------------------
   typedef logic [31:0] smc_addr_t;     // Byte address
   typedef logic [1:0]  smc_size_t;     // Transfer or bus size code

   // Remaining accesses of a transfer, minus one
   typedef logic [1:0]  smc_acc_cnt_t;

   typedef logic [`SMC_WAIT_W-1:0] smc_wait_t;   // Wait states per access

   // Byte lane enables, low active, bit k is lane k
   typedef logic [3:0]  smc_n_be_t;

   // ------------------------------
   // Sequencer states
   // ------------------------------
   typedef enum logic
   {
      SMC_IDLE = 1'b0,                  // No transfer running
      SMC_RW   = 1'b1                   // External access in progress
   } smc_state_t;

endpackage

`default_nettype wire

//--- verification/smc_lite_sva.sv
`timescale 1ns/1ps
`default_nettype none

module smc_lite_sva
(
   input wire                     sys_clk4,
   input wire                     n_sys_reset4,
   input wire                     req_valid,
   input wire                     busy,
   input wire                     xfer_done,
   input wire                     smc_n_cs,
   input wire smc_pkg::smc_n_be_t smc_n_be
);

   int unsigned fail_cnt = 0;     // Count of failed assertions

   // ------------------------------
   // Host handshake
   // ------------------------------
   // No back-pressure, so a strobe while busy would be lost
   no_req_while_busy: assert property (@(posedge sys_clk4) disable iff (!n_sys_reset4)
      busy |-> !req_valid)
   else
   begin
      fail_cnt++;
      $error("request strobe while busy");
   end

   done_one_cycle: assert property (@(posedge sys_clk4) disable iff (!n_sys_reset4)
      xfer_done |=> !xfer_done)
   else
   begin
      fail_cnt++;                 // Pulse held too long
      $error("xfer_done longer than one cycle");
   end

   // ------------------------------
   // External strobes
   // ------------------------------
   cs_idle_high: assert property (@(posedge sys_clk4) disable iff (!n_sys_reset4)
      !busy |-> smc_n_cs)
   else
   begin
      fail_cnt++;
      $error("smc_n_cs low while idle");
   end

   be_needs_cs: assert property (@(posedge sys_clk4) disable iff (!n_sys_reset4)
      (smc_n_be != 4'hF) |-> !smc_n_cs)
   else
   begin
      fail_cnt++;                 // Lanes without a chip select
      $error("smc_n_be active while smc_n_cs high");
   end

endmodule

bind smc_lite_top smc_lite_sva sva_i
(
   .sys_clk4     (sys_clk4),
   .n_sys_reset4 (n_sys_reset4),
   .req_valid    (req_valid),
   .busy         (busy),
   .xfer_done    (xfer_done),
   .smc_n_cs     (smc_n_cs),
   .smc_n_be     (smc_n_be)
);

`default_nettype wire

//--- verification/smc_lite_tb.sv
`timescale 1ns/1ps
`include "smc_params.svh"
`default_nettype none

module smc_lite_tb;

   logic                  sys_clk4 = 1'b0;
   logic                  n_sys_reset4;
   logic                  req_valid;
   smc_pkg::smc_addr_t    req_addr;
   smc_pkg::smc_size_t    req_xfer_size;
   logic                  req_cs;
   smc_pkg::smc_size_t    bus_size;
   smc_pkg::smc_wait_t    wait_states;
   logic                  busy;
   logic                  xfer_done;
   logic                  req_error;
   smc_pkg::smc_addr_t    smc_addr;
   logic                  smc_n_cs;
   smc_pkg::smc_n_be_t    smc_n_be;
   logic [31:0]           rng_state = 32'h6d08_5464;

   always #20 sys_clk4 = ~sys_clk4;               // 40 ns period

   smc_lite_top smc_lite_i
   (
      .sys_clk4      (sys_clk4),
      .n_sys_reset4  (n_sys_reset4),
      .req_valid     (req_valid),
      .req_addr      (req_addr),
      .req_xfer_size (req_xfer_size),
      .req_cs        (req_cs),
      .bus_size      (bus_size),
      .wait_states   (wait_states),
      .busy          (busy),
      .xfer_done     (xfer_done),
      .req_error     (req_error),
      .smc_addr      (smc_addr),
      .smc_n_cs      (smc_n_cs),
      .smc_n_be      (smc_n_be)
   );

   // ------------------------------
   // Error exit and checks
   // ------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
         abort_run($sformatf("error: %s got %0h expected %0h", name, got, exp));
   endtask

   // Watch the bound protocol checker
   always @(negedge sys_clk4)
      if (smc_lite_i.sva_i.fail_cnt != 0)
         abort_run("a protocol assertion failed");

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic int access_count(input logic [1:0] xs, input logic [1:0] bs);
      if (xs == `SMC_XSIZ_32 && bs == `SMC_BSIZ_8)
         return 4;
      if ((xs == `SMC_XSIZ_32 && bs == `SMC_BSIZ_16) || (xs == `SMC_XSIZ_16 && bs == `SMC_BSIZ_8))
         return 2;
      return 1;                                    // Fits the bus
   endfunction

   function automatic logic [1:0] low_bits(input logic [1:0] xs, input logic [1:0] bs,
                                           input logic [1:0] a, input int idx);
      if (xs == `SMC_XSIZ_32)
         return (bs == `SMC_BSIZ_8) ? 2'(3 - idx) : (bs == `SMC_BSIZ_16 && idx == 0) ? 2'd2 : 2'd0;
      if (xs == `SMC_XSIZ_16)
         return {a[1], (bs == `SMC_BSIZ_8 && idx == 0)};   // Odd byte first on 8 bit bus
      return a;
   endfunction

   function automatic logic [3:0] lane_enables(input logic [1:0] xs, input logic [1:0] bs,
                                               input logic [1:0] lo, input logic cs);
      if (!cs)
         return 4'b1111;
      if (bs == `SMC_BSIZ_8)
         return 4'b1110;
      if (bs == `SMC_BSIZ_16)
         return (xs == `SMC_XSIZ_8) ? (lo[0] ? 4'b1101 : 4'b1110) : 4'b1100;
      if (xs == `SMC_XSIZ_16)
         return lo[1] ? 4'b0011 : 4'b1100;
      if (xs == `SMC_XSIZ_32)
         return 4'b0000;
      case (lo)                                    // Byte on 32 bit bus
         2'd0: return 4'b1110;
         2'd1: return 4'b1101;
         2'd2: return 4'b1011;
         default: return 4'b0111;
      endcase
   endfunction

   // ------------------------------
   // One request and its accesses
   // ------------------------------
   task automatic run_transfer(input logic [1:0] xs, input logic [1:0] bs, input logic [1:0] w,
                               input logic cs, input logic [31:0] addr);
      int n;
      int cyc;
      logic [1:0] lo;
      n = access_count(xs, (bs == 2'd3) ? `SMC_BSIZ_32 : bs);
      cyc = 0;
      req_valid     = 1'b1;
      req_addr      = addr;
      req_xfer_size = xs;
      req_cs        = cs;
      bus_size      = bs;
      wait_states   = w;
      @(negedge sys_clk4);
      // Stale request fields must be ignored
      req_valid     = 1'b0;
      req_addr      = ~addr;
      req_xfer_size = ~xs;
      req_cs        = ~cs;
      if (xs == 2'd3)
      begin
         repeat (2)
         begin
            check_hex("req_error", req_error, (cyc == 0)); // One pulse only
            check_hex("busy", busy, 0);
            check_hex("smc_n_cs", smc_n_cs, 1);
            check_hex("smc_n_be", smc_n_be, 4'hF);
            check_hex("xfer_done", xfer_done, 0);
            cyc = 1;
            @(negedge sys_clk4);
         end
         return;
      end
      while (xfer_done !== 1'b1)                   // Bounded by the expected length
      begin
         if (cyc >= n * (w + 1))
            abort_run("transfer ran past its expected length without xfer_done");
         lo = low_bits(xs, (bs == 2'd3) ? `SMC_BSIZ_32 : bs, addr[1:0], cyc / (w + 1));
         check_hex("req_error", req_error, 0);
         check_hex("busy", busy, 1);
         check_hex("smc_n_cs", smc_n_cs, !cs);
         check_hex("smc_addr", smc_addr, {addr[31:2], lo});
         check_hex("smc_n_be", smc_n_be,
                   lane_enables(xs, (bs == 2'd3) ? `SMC_BSIZ_32 : bs, lo, cs));
         cyc++;
         @(negedge sys_clk4);
      end
      check_hex("access cycles", cyc, n * (w + 1));
      check_hex("busy", busy, 0);
      check_hex("smc_n_cs", smc_n_cs, 1);
      check_hex("smc_n_be", smc_n_be, 4'hF);       // Released with xfer_done
      @(negedge sys_clk4);
      check_hex("xfer_done", xfer_done, 0);
   endtask

   // ------------------------------
   // Stimulus
   // ------------------------------
   initial
   begin
      n_sys_reset4  = 1'b0;
      req_valid     = 1'b0;
      req_addr      = '0;
      req_xfer_size = '0;
      req_cs        = 1'b0;
      bus_size      = '0;
      wait_states   = '0;
      repeat (3) @(posedge sys_clk4);
      @(negedge sys_clk4);
      n_sys_reset4 = 1'b1;
      check_hex("busy", busy, 0);
      check_hex("xfer_done", xfer_done, 0);
      check_hex("req_error", req_error, 0);
      check_hex("smc_n_cs", smc_n_cs, 1);
      check_hex("smc_n_be", smc_n_be, 4'hF);
      check_hex("smc_addr", smc_addr, 0);
      for (int xs = 0; xs < 4; xs++)               // Size 3 is the illegal code
         for (int bs = 0; bs < 4; bs++)
            for (int w = 0; w < 4; w++)
               for (int cs = 0; cs < 2; cs++)
               begin
                  rng_state = xorshift(rng_state);
                  run_transfer(2'(xs), 2'(bs), 2'(w), cs[0], rng_state);
                  repeat (rng_state[5:4]) @(negedge sys_clk4);   // Idle gap
               end
      if (smc_lite_i.sva_i.fail_cnt != 0)
         abort_run("a protocol assertion failed");
      else
      begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

`default_nettype wire
